/* verilog/rv32e_config.svh */
`ifndef RV32E_CONFIG_SVH
`define RV32E_CONFIG_SVH

// Fetch address after reset
`define RV32E_RESET_PC 32'h0000_0000

// Architectural data width
`define RV32E_XLEN 32

// RV32E register count, x0 included
`define RV32E_NREGS 16

`endif

/* verilog/rv32e_isa_pkg.sv */
package rv32e_isa_pkg;

    // Field widths of the base instruction formats
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;
    localparam int reg_addr_w = 4;

    // RV32E keeps only the low four bits of each register field
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // Major opcodes kept by this core
    typedef enum logic [opcode_w-1:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_t;

    // Conditional branch conditions
    typedef enum logic [funct3_w-1:0] {
        f3_beq  = 3'b000,
        f3_bne  = 3'b001,
        f3_blt  = 3'b100,
        f3_bge  = 3'b101,
        f3_bltu = 3'b110,
        f3_bgeu = 3'b111
    } branch_f3_t;

    // ALU function codes, shared by op and op_imm
    typedef enum logic [funct3_w-1:0] {
        f3_add_sub = 3'b000,
        f3_sll     = 3'b001,
        f3_slt     = 3'b010,
        f3_sltu    = 3'b011,
        f3_xor     = 3'b100,
        f3_srl_sra = 3'b101,
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } alu_f3_t;

    // Word size code, the only one accepted for loads and stores
    localparam logic [funct3_w-1:0] f3_word = 3'b010;

endpackage

/* verilog/rv32e_ctrl_pkg.sv */
package rv32e_ctrl_pkg;

    // ALU operation, pass_b serves lui
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b
    } alu_op_t;

    // First ALU operand
    typedef enum logic {
        a_rs1,
        a_pc
    } a_sel_t;

    // Second ALU operand
    typedef enum logic {
        b_rs2,
        b_imm
    } b_sel_t;

    // Register writeback source
    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_pc4
    } wb_sel_t;

    // How the next pc is formed
    typedef enum logic [1:0] {
        brk_none,
        brk_cond,
        brk_jal,
        brk_jalr
    } br_kind_t;

endpackage

/* verilog/ctrl_if.sv */
`timescale 1ns/100ps
`include "rv32e_config.svh"

interface ctrl_if import rv32e_isa_pkg::*, rv32e_ctrl_pkg::*; ();

    reg_addr_t              rs1;
    reg_addr_t              rs2;
    reg_addr_t              rd;
    logic [`RV32E_XLEN-1:0] imm;
    alu_op_t                alu_op;
    a_sel_t                 a_sel;
    b_sel_t                 b_sel;
    br_kind_t               br_kind;
    branch_f3_t             br_f3;
    logic                   reg_we;
    logic                   mem_we;
    wb_sel_t                wb_sel;

    // Decoder side
    modport source (
        output rs1, rs2, rd, imm, alu_op, a_sel, b_sel,
        output br_kind, br_f3, reg_we, mem_we, wb_sel
    );

    // Execute and load/store side
    modport sink (
        input rs1, rs2, rd, imm, alu_op, a_sel, b_sel,
        input br_kind, br_f3, reg_we, mem_we, wb_sel
    );

endinterface

/* verilog/rv32e_decode.sv */
`timescale 1ns/100ps
`include "rv32e_config.svh"

module rv32e_decode import rv32e_isa_pkg::*, rv32e_ctrl_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n,
    input  logic [`RV32E_XLEN-1:0] instr,
    input  logic [`RV32E_XLEN-1:0] next_pc,
    output logic [`RV32E_XLEN-1:0] pc,
    ctrl_if.source                 ctrl
);

    logic [opcode_w-1:0]    opcode;
    logic [funct3_w-1:0]    funct3;
    logic [funct7_w-1:0]    funct7;
    alu_f3_t                alu_f3;
    logic                   alt;
    logic                   op_ok;
    logic                   shift_ok;
    logic [`RV32E_XLEN-1:0] imm_i;
    logic [`RV32E_XLEN-1:0] imm_s;
    logic [`RV32E_XLEN-1:0] imm_b;
    logic [`RV32E_XLEN-1:0] imm_u;
    logic [`RV32E_XLEN-1:0] imm_j;

    function automatic alu_op_t alu_from_f3(input alu_f3_t f3, input logic sel_alt);
        alu_op_t op;
        case (f3)
            f3_add_sub: op = sel_alt ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = sel_alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            default:    op = alu_and;
        endcase
        return op;
    endfunction

    // Program counter
    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            pc <= `RV32E_RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // Fixed instruction fields
    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign alu_f3    = alu_f3_t'(funct3);
    assign ctrl.rd   = instr[10:7];
    assign ctrl.rs1  = instr[18:15];
    assign ctrl.rs2  = instr[23:20];
    assign ctrl.br_f3 = branch_f3_t'(funct3);

    // funct7 of 0100000 picks sub and sra
    assign alt   = funct7 == 7'b0100000;
    assign op_ok = (funct7 == '0) || (alt && (alu_f3 == f3_add_sub || alu_f3 == f3_srl_sra));
    assign shift_ok = (alu_f3 == f3_sll) ? (funct7 == '0) :
                      (alu_f3 == f3_srl_sra) ? (funct7 == '0 || alt) : 1'b1;

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // Anything not matched below stays a nop
        ctrl.imm     = imm_i;
        ctrl.alu_op  = alu_add;
        ctrl.a_sel   = a_rs1;
        ctrl.b_sel   = b_imm;
        ctrl.wb_sel  = wb_alu;
        ctrl.br_kind = brk_none;
        ctrl.reg_we  = 1'b0;
        ctrl.mem_we  = 1'b0;
        case (opcode_t'(opcode))
            opc_op: begin
                ctrl.b_sel  = b_rs2;
                ctrl.alu_op = alu_from_f3(alu_f3, alt);
                ctrl.reg_we = op_ok;
            end
            opc_op_imm: begin
                ctrl.alu_op = alu_from_f3(alu_f3, alt && alu_f3 == f3_srl_sra);
                ctrl.reg_we = shift_ok;
            end
            opc_lui: begin
                ctrl.imm    = imm_u;
                ctrl.alu_op = alu_pass_b;
                ctrl.reg_we = 1'b1;
            end
            opc_auipc: begin
                ctrl.imm    = imm_u;
                ctrl.a_sel  = a_pc;
                ctrl.reg_we = 1'b1;
            end
            opc_jal: begin
                ctrl.imm     = imm_j;
                ctrl.wb_sel  = wb_pc4;
                ctrl.br_kind = brk_jal;
                ctrl.reg_we  = 1'b1;
            end
            opc_jalr: begin
                if (funct3 == '0) begin
                    ctrl.wb_sel  = wb_pc4;
                    ctrl.br_kind = brk_jalr;
                    ctrl.reg_we  = 1'b1;
                end
            end
            opc_branch: begin
                ctrl.imm   = imm_b;
                ctrl.b_sel = b_rs2;
                if (ctrl.br_f3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu}) begin
                    ctrl.br_kind = brk_cond;
                end
            end
            opc_load: begin
                ctrl.wb_sel = wb_load;
                ctrl.reg_we = funct3 == f3_word;
            end
            opc_store: begin
                ctrl.imm    = imm_s;
                ctrl.mem_we = funct3 == f3_word;
            end
            default: ;
        endcase
        // No architectural writes while in reset
        if (!rst_n) begin
            ctrl.reg_we = 1'b0;
            ctrl.mem_we = 1'b0;
        end
    end

endmodule

/* verilog/rv32e_execute.sv */
`timescale 1ns/100ps
`include "rv32e_config.svh"

module rv32e_execute import rv32e_isa_pkg::*, rv32e_ctrl_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n,
    ctrl_if.sink                   ctrl,
    input  logic [`RV32E_XLEN-1:0] pc,
    input  logic [`RV32E_XLEN-1:0] wb_data,
    output logic [`RV32E_XLEN-1:0] alu_result,
    output logic [`RV32E_XLEN-1:0] rs2_data,
    output logic [`RV32E_XLEN-1:0] next_pc
);

    localparam int shamt_w = $clog2(`RV32E_XLEN);

    // x0 has no storage
    logic [`RV32E_XLEN-1:0] regs [1:`RV32E_NREGS-1];

    logic [`RV32E_XLEN-1:0] rs1_data;
    logic [`RV32E_XLEN-1:0] op_a;
    logic [`RV32E_XLEN-1:0] op_b;
    logic [shamt_w-1:0]     shamt;
    logic [`RV32E_XLEN-1:0] pc_plus4;
    logic [`RV32E_XLEN-1:0] pc_target;
    logic                   br_eq;
    logic                   br_lt;
    logic                   br_ltu;
    logic                   br_taken;

    // Register file, written at the end of the cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV32E_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_we && ctrl.rd != '0) begin
            regs[ctrl.rd] <= wb_data;
        end
    end

    assign rs1_data = (ctrl.rs1 == '0) ? '0 : regs[ctrl.rs1];
    assign rs2_data = (ctrl.rs2 == '0) ? '0 : regs[ctrl.rs2];

    // Operand selection
    assign op_a  = (ctrl.a_sel == a_pc) ? pc : rs1_data;
    assign op_b  = (ctrl.b_sel == b_imm) ? ctrl.imm : rs2_data;
    assign shamt = op_b[shamt_w-1:0];

    always_comb begin
        case (ctrl.alu_op)
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_sll:    alu_result = op_a << shamt;
            alu_srl:    alu_result = op_a >> shamt;
            alu_sra:    alu_result = $signed(op_a) >>> shamt;
            alu_slt:    alu_result = {{(`RV32E_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_result = {{(`RV32E_XLEN-1){1'b0}}, op_a < op_b};
            alu_pass_b: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    // Branch comparator works on the raw register values
    assign br_eq  = rs1_data == rs2_data;
    assign br_lt  = $signed(rs1_data) < $signed(rs2_data);
    assign br_ltu = rs1_data < rs2_data;

    always_comb begin
        case (ctrl.br_f3)
            f3_beq:  br_taken = br_eq;
            f3_bne:  br_taken = !br_eq;
            f3_blt:  br_taken = br_lt;
            f3_bge:  br_taken = !br_lt;
            f3_bltu: br_taken = br_ltu;
            f3_bgeu: br_taken = !br_ltu;
            default: br_taken = 1'b0;
        endcase
    end

    // Next pc
    assign pc_plus4  = pc + `RV32E_XLEN'(4);
    assign pc_target = pc + ctrl.imm;

    always_comb begin
        case (ctrl.br_kind)
            brk_cond: next_pc = br_taken ? pc_target : pc_plus4;
            brk_jal:  next_pc = pc_target;
            brk_jalr: next_pc = {alu_result[`RV32E_XLEN-1:1], 1'b0};
            default:  next_pc = pc_plus4;
        endcase
    end

endmodule

/* verilog/rv32e_lsu.sv */
`timescale 1ns/100ps
`include "rv32e_config.svh"

module rv32e_lsu import rv32e_ctrl_pkg::*; (
    ctrl_if.sink                   ctrl,
    input  logic [`RV32E_XLEN-1:0] pc,
    input  logic [`RV32E_XLEN-1:0] alu_result,
    input  logic [`RV32E_XLEN-1:0] rs2_data,
    input  logic [`RV32E_XLEN-1:0] mem_rdata,
    output logic                   mem_we,
    output logic [`RV32E_XLEN-1:0] mem_addr,
    output logic [`RV32E_XLEN-1:0] mem_wdata,
    output logic [`RV32E_XLEN-1:0] wb_data
);

    logic [`RV32E_XLEN-1:0] pc_plus4;

    // Word bus, the memory drops address bits 1:0
    assign mem_we    = ctrl.mem_we;
    assign mem_addr  = alu_result;
    assign mem_wdata = rs2_data;

    // Link address for jal and jalr
    assign pc_plus4 = pc + `RV32E_XLEN'(4);

    always_comb begin
        case (ctrl.wb_sel)
            wb_load: wb_data = mem_rdata;
            wb_pc4:  wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

endmodule

/* verilog/rv32e_core.sv */
`timescale 1ns/100ps
`include "rv32e_config.svh"

module rv32e_core (
    input  logic                   clk_i,
    input  logic                   rst_n,

    // Instruction fetch
    output logic [`RV32E_XLEN-1:0] pc,
    input  logic [`RV32E_XLEN-1:0] instr,

    // Data bus
    output logic                   mem_we,
    output logic [`RV32E_XLEN-1:0] mem_addr,
    output logic [`RV32E_XLEN-1:0] mem_wdata,
    input  logic [`RV32E_XLEN-1:0] mem_rdata
);

    logic [`RV32E_XLEN-1:0] next_pc;
    logic [`RV32E_XLEN-1:0] alu_result;
    logic [`RV32E_XLEN-1:0] rs2_data;
    logic [`RV32E_XLEN-1:0] wb_data;

    ctrl_if ctrl_bus ();

    rv32e_decode i_decode (
        .clk_i   (clk_i),
        .rst_n   (rst_n),
        .instr   (instr),
        .next_pc (next_pc),
        .pc      (pc),
        .ctrl    (ctrl_bus.source)
    );

    rv32e_execute i_execute (
        .clk_i      (clk_i),
        .rst_n      (rst_n),
        .ctrl       (ctrl_bus.sink),
        .pc         (pc),
        .wb_data    (wb_data),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .next_pc    (next_pc)
    );

    rv32e_lsu i_lsu (
        .ctrl       (ctrl_bus.sink),
        .pc         (pc),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .mem_rdata  (mem_rdata),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .wb_data    (wb_data)
    );

endmodule

/* tb/rv32e_model.svh */
`ifndef RV32E_MODEL_SVH
`define RV32E_MODEL_SVH

// Reference architectural state
logic [31:0] ref_regs [0:15];
logic [31:0] ref_mem [0:255];
logic [31:0] ref_pc;

function automatic logic [31:0] alu_result_of(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'd0, $signed(a) < $signed(b)};
        3'd3: return {31'd0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

task automatic reset_model_state();
    ref_pc = `RV32E_RESET_PC;
    for (int i = 0; i < 16; i++) begin
        ref_regs[i] = '0;
    end
endtask

// Executes one instruction and reports the store it makes
task automatic reference_step(input logic [31:0] ins, output logic st_we,
                              output logic [31:0] st_addr, output logic [31:0] st_data);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] ea;
    logic [31:0] wval;
    logic [31:0] next;
    logic        wr;
    logic        taken;
    a       = ref_regs[ins[18:15]];
    b       = ref_regs[ins[23:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    next    = ref_pc + 32'd4;
    wr      = 1'b1;
    wval    = '0;
    st_we   = 1'b0;
    st_addr = '0;
    st_data = b;
    case (ins[6:0])
        7'b0110011: wval = alu_result_of(ins[14:12], ins[30], a, b);
        7'b0010011: wval = alu_result_of(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
        7'b0110111: wval = {ins[31:12], 12'd0};
        7'b0010111: wval = ref_pc + {ins[31:12], 12'd0};
        7'b1101111: begin
            wval = ref_pc + 32'd4;
            next = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        7'b1100111: begin
            wval = ref_pc + 32'd4;
            next = (a + imm_i) & ~32'd1;
        end
        7'b1100011: begin
            wr = 1'b0;
            case (ins[14:12])
                3'd0: taken = a == b;
                3'd1: taken = a != b;
                3'd4: taken = $signed(a) < $signed(b);
                3'd5: taken = $signed(a) >= $signed(b);
                3'd6: taken = a < b;
                default: taken = a >= b;
            endcase
            if (taken) begin
                next = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
        end
        7'b0000011: begin
            ea   = a + imm_i;
            wval = ref_mem[ea[9:2]];
        end
        default: begin
            // Store, the only other encoding the generator makes
            wr      = 1'b0;
            st_we   = 1'b1;
            st_addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            ref_mem[st_addr[9:2]] = b;
        end
    endcase
    if (wr && ins[10:7] != 4'd0) begin
        ref_regs[ins[10:7]] = wval;
    end
    ref_pc = next;
endtask

`endif

/* tb/rv32e_tb.sv */
`timescale 1ns/100ps
`include "rv32e_config.svh"

module rv32e_tb;

    localparam int reset_cycles = 10;
    localparam int num_instr    = 2000;
    // One cycle per instruction after reset, plus margin
    localparam int cycle_limit  = reset_cycles + num_instr + 90;
    localparam logic [31:0] lfsr_seed = 32'h5993_8838;

    logic        clk_i = 1'b0;
    logic        rst_n;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;

    logic [31:0] dmem [0:255];
    logic [31:0] lfsr;
    int          cycle_count = 0;
    int          error_count = 0;

    `include "rv32e_model.svh"

    rv32e_core i_rv32e_core (.*);

    always #2 clk_i = ~clk_i;

    // Data memory as the DUT sees it, read within the cycle
    assign mem_rdata = dmem[mem_addr[9:2]];

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (mem_we) begin
            dmem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    initial begin
        wait (cycle_count >= cycle_limit);
        $display("sim failed");
        $fatal(1, "timeout: the run did not finish within %0d cycles", cycle_limit);
    end

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_advance(lfsr);
        end
        return r;
    endfunction

    function automatic logic [31:0] random_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [11:0] ls;
        logic [4:0]  w;
        logic [20:0] off;
        rd  = 5'(take_bits(4));
        rs1 = 5'(take_bits(4));
        rs2 = 5'(take_bits(4));
        f3  = 3'(take_bits(3));
        f7  = (1'(take_bits(1)) && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        imm = 12'(take_bits(12));
        // Word offset from -64 to +60 bytes
        w   = 5'(take_bits(5));
        off = {{14{w[4]}}, w, 2'b00};
        // x0 base, one of 256 words
        ls  = {2'b00, 8'(take_bits(8)), 2'b00};
        case (4'(take_bits(4)))
            4'd0, 4'd1, 4'd2: return {f7, rs2, rs1, f3, rd, 7'b0110011};
            4'd3, 4'd4, 4'd5: begin
                if (f3 == 3'd1) begin
                    imm = {7'h00, imm[4:0]};
                end else if (f3 == 3'd5) begin
                    imm = {f7, imm[4:0]};
                end
                return {imm, rs1, f3, rd, 7'b0010011};
            end
            4'd6: return {imm, rs1, f3, rd, 7'b0110111};
            4'd7: return {imm, rs1, f3, rd, 7'b0010111};
            4'd8: return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
            4'd9: return {imm, rs1, 3'b000, rd, 7'b1100111};
            4'd10, 4'd11: begin
                // funct3 2 and 3 are not branches
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
            end
            4'd12, 4'd13: return {ls, 5'd0, 3'b010, rd, 7'b0000011};
            default: return {ls[11:5], rs2, 5'd0, 3'b010, ls[4:0], 7'b0100011};
        endcase
    endfunction

    task automatic report_mismatch(input string what);
        error_count++;
        $display("sim failed");
        $display("mismatch at %0t: %s", $time, what);
        $fatal(1, "stopped at the first error");
    endtask

    initial begin
        logic [31:0] cur;
        logic        dut_we;
        logic [31:0] dut_addr;
        logic [31:0] dut_wdata;
        logic        exp_we;
        logic [31:0] exp_addr;
        logic [31:0] exp_wdata;
        rst_n = 1'b0;
        instr = 32'h0000_0013;
        lfsr  = lfsr_seed;
        for (int i = 0; i < 256; i++) begin
            dmem[i]    = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'h3c};
            ref_mem[i] = dmem[i];
        end
        reset_model_state();
        // Word stores with random fields, all blocked while in reset
        repeat (reset_cycles) begin
            cur   = random_instr();
            instr = {cur[31:15], 3'b010, cur[11:7], 7'b0100011};
            #1;
            assert (mem_we === 1'b0)
                else report_mismatch("mem_we high during reset");
            @(negedge clk_i);
        end
        rst_n = 1'b1;
        assert (pc === `RV32E_RESET_PC)
            else report_mismatch($sformatf("pc %h after reset", pc));
        for (int n = 0; n < num_instr; n++) begin
            assert (pc === ref_pc)
                else report_mismatch($sformatf("pc %h, expected %h", pc, ref_pc));
            cur   = random_instr();
            instr = cur;
            #1;
            dut_we    = mem_we;
            dut_addr  = mem_addr;
            dut_wdata = mem_wdata;
            @(posedge clk_i);
            reference_step(cur, exp_we, exp_addr, exp_wdata);
            assert (dut_we === exp_we)
                else report_mismatch($sformatf("mem_we %b for instr %h", dut_we, cur));
            assert (!exp_we || (dut_addr === exp_addr && dut_wdata === exp_wdata))
                else report_mismatch($sformatf("store %h <- %h, expected %h <- %h",
                                               dut_addr, dut_wdata, exp_addr, exp_wdata));
            @(negedge clk_i);
        end
        // Next pc of the last instruction
        assert (pc === ref_pc)
            else report_mismatch($sformatf("final pc %h, expected %h", pc, ref_pc));
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+verilog
+incdir+tb
verilog/rv32e_isa_pkg.sv
verilog/rv32e_ctrl_pkg.sv
verilog/ctrl_if.sv
verilog/rv32e_decode.sv
verilog/rv32e_execute.sv
verilog/rv32e_lsu.sv
verilog/rv32e_core.sv
tb/rv32e_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run; success only if the pass line shows up
cd "$(dirname "$0")" &&
    verilator --binary --timing --timescale 1ns/100ps --top-module rv32e_tb -f sources.f &&
    ./obj_dir/Vrv32e_tb | tee /dev/stderr | grep -qx "sim passed" &&
    echo "PASS" ||
    { echo "FAIL"; exit 1; }
